//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module cluster_tb -Mdir obj_dir
	./obj_dir/Vcluster_tb | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bench/cluster_chk.sv
module cluster_chk
    import cluster_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    io_req_valid,
    input io_req_t io_req,
    input logic    io_req_ready,
    input logic    csr_io_rsp_valid,
    input word_t   csr_io_rsp_data,
    input logic    csr_io_rsp_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    io_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        io_req_valid && !io_req_ready |=> io_req_valid && $stable(io_req))
        else $error("I/O request dropped or changed while stalled");

    csr_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        csr_io_rsp_valid && !csr_io_rsp_ready |=> csr_io_rsp_valid && $stable(csr_io_rsp_data))
        else $error("CSR response dropped or changed while stalled");

    // Nothing may leave the cluster right at reset release
    no_req_at_release: assert property (@(posedge clk) $rose(arst_n) |-> !io_req_valid)
        else $error("I/O request valid at reset release");

    no_req_after_release: assert property (@(posedge clk) $rose(arst_n) |=> !io_req_valid)
        else $error("I/O request valid one cycle after reset release");

endmodule

bind cluster_top cluster_chk u_chk (
    .clk              (clk),
    .arst_n           (arst_n),
    .io_req_valid     (io_req_valid),
    .io_req           (io_req),
    .io_req_ready     (io_req_ready),
    .csr_io_rsp_valid (csr_io_rsp_valid),
    .csr_io_rsp_data  (csr_io_rsp_data),
    .csr_io_rsp_ready (csr_io_rsp_ready)
);

//--- bench/cluster_tb.sv
module cluster_tb
    import cluster_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int N_OPS        = 300;
    localparam int OP_CYCLES    = 40;
    localparam int WATCHDOG_NS  = (N_OPS * OP_CYCLES + 200) * CLK_PERIOD;

    logic     clk;
    logic     arst_n;
    logic     csr_io_req_valid;
    core_id_t csr_io_req_coreid;
    csr_req_t csr_io_req;
    logic     csr_io_req_ready;
    logic     csr_io_rsp_valid;
    word_t    csr_io_rsp_data;
    logic     csr_io_rsp_ready;
    logic     io_req_valid;
    io_req_t  io_req;
    logic     io_req_ready;
    logic     io_rsp_valid;
    io_rsp_t  io_rsp;
    logic     io_rsp_ready;
    logic     busy;
    logic     ebreak;

    int seed;
    int io_seed;
    int cycle;
    int outstanding;
    int launch_total;
    int xfer_total;
    int stall_left;
    logic rsp_shown;

    // Host view of each core
    word_t m_addr[NUM_CORES];
    word_t m_data[NUM_CORES];
    word_t m_ebreak_csr[NUM_CORES];
    word_t m_rdata[NUM_CORES];
    logic  m_rdata_ok[NUM_CORES];
    logic [NUM_CORES-1:0] m_ebreak_set;
    core_tag_t m_launches[NUM_CORES];
    io_req_t exp_req[NUM_CORES][16];
    logic    exp_live[NUM_CORES][16];

    // I/O memory model and its pending read responses
    word_t   mem[io_addr_t];
    word_t   rsp_data_q[$];
    io_tag_t rsp_tag_q[$];
    int      rsp_due_q[$];

    cluster_top u_cluster_top (
        .clk               (clk),
        .arst_n            (arst_n),
        .csr_io_req_valid  (csr_io_req_valid),
        .csr_io_req_coreid (csr_io_req_coreid),
        .csr_io_req        (csr_io_req),
        .csr_io_req_ready  (csr_io_req_ready),
        .csr_io_rsp_valid  (csr_io_rsp_valid),
        .csr_io_rsp_data   (csr_io_rsp_data),
        .csr_io_rsp_ready  (csr_io_rsp_ready),
        .io_req_valid      (io_req_valid),
        .io_req            (io_req),
        .io_req_ready      (io_req_ready),
        .io_rsp_valid      (io_rsp_valid),
        .io_rsp            (io_rsp),
        .io_rsp_ready      (io_rsp_ready),
        .busy              (busy),
        .ebreak            (ebreak)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int io_rand_below(input int n);
        return int'($unsigned($random(io_seed)) % n);
    endfunction

    // Unwritten words depend on every address bit
    function automatic word_t fill_word(input io_addr_t a);
        return {a, 2'b01} ^ {a[13:0], a[29:12]};
    endfunction

    function automatic word_t mem_read(input io_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata,
                                          input byteen_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t expected_csr(input core_id_t c, input csr_addr_t addr);
        case (addr)
            CSR_IO_ADDR:  return m_addr[c];
            CSR_IO_DATA:  return m_data[c];
            CSR_IO_RDATA: return m_rdata[c];
            CSR_EBREAK:   return m_ebreak_csr[c];
            default:      return '0;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic note_csr_write(input core_id_t c, input csr_req_t r);
        core_tag_t ct;
        io_req_t   e;
        case (r.addr)
            CSR_IO_ADDR: m_addr[c] = r.data;
            CSR_IO_DATA: m_data[c] = r.data;
            CSR_EBREAK: begin
                m_ebreak_csr[c] = r.data;
                if (r.data[0]) begin
                    m_ebreak_set[c] = 1'b1;
                end
            end
            CSR_IO_CMD: begin
                m_launches[c] = m_launches[c] + 1'b1;
                ct = m_launches[c];
                e.rw     = r.data[0];
                e.byteen = r.data[4:1];
                e.addr   = m_addr[c][29:0];
                e.data   = m_data[c];
                e.tag    = {ct, c};
                exp_req[c][ct]  = e;
                exp_live[c][ct] = 1'b1;
                outstanding++;
                launch_total++;
            end
            default: ;
        endcase
    endtask

    task automatic check_io_req(input io_req_t r);
        core_id_t  c;
        core_tag_t ct;
        c  = r.tag[NC_BITS-1:0];
        ct = r.tag[CORE_TAG_W+NC_BITS-1:NC_BITS];
        assert (exp_live[c][ct]) else
            fail_run($sformatf("unexpected I/O request with tag %h", r.tag));
        assert (r == exp_req[c][ct]) else
            fail_run($sformatf("I/O request %h, expected %h", r, exp_req[c][ct]));
        exp_live[c][ct] = 1'b0;
        xfer_total++;
        if (r.rw) begin
            mem[r.addr] = merge_bytes(mem_read(r.addr), r.data, r.byteen);
            outstanding--;
        end else begin
            rsp_data_q.push_back(mem_read(r.addr));
            rsp_tag_q.push_back(r.tag);
            rsp_due_q.push_back(cycle + io_rand_below(6));
        end
    endtask

    // Monitor, I/O memory model and ready stretches
    always @(posedge clk) begin
        if (arst_n) begin
            cycle++;
            assert (busy == (outstanding != 0)) else
                fail_run($sformatf("busy %0b with %0d launches open", busy, outstanding));
            assert (ebreak == (&m_ebreak_set)) else
                fail_run($sformatf("ebreak %0b, cores set %b", ebreak, m_ebreak_set));
            // The addressed core sits in its wait state
            assert (!io_rsp_valid || io_rsp_ready) else
                fail_run("read response refused by the waiting core");
            if (csr_io_req_valid && csr_io_req_ready && csr_io_req.rw) begin
                note_csr_write(csr_io_req_coreid, csr_io_req);
            end
            if (io_req_valid && io_req_ready) begin
                check_io_req(io_req);
            end
            if (io_rsp_valid && io_rsp_ready) begin
                m_rdata[io_rsp.tag[NC_BITS-1:0]]    = io_rsp.data;
                m_rdata_ok[io_rsp.tag[NC_BITS-1:0]] = 1'b1;
                outstanding--;
                void'(rsp_data_q.pop_front());
                void'(rsp_tag_q.pop_front());
                void'(rsp_due_q.pop_front());
                rsp_shown = 1'b0;
            end

            if (stall_left > 0) begin
                stall_left--;
                io_req_ready <= 1'b0;
            end else if (io_rand_below(8) == 0) begin
                stall_left = io_rand_below(12);
                io_req_ready <= 1'b0;
            end else begin
                io_req_ready <= 1'b1;
            end

            if (!rsp_shown && rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
                io_rsp_valid <= 1'b1;
                io_rsp       <= {rsp_data_q[0], rsp_tag_q[0]};
                rsp_shown = 1'b1;
            end else if (!rsp_shown) begin
                io_rsp_valid <= 1'b0;
            end
        end
    end

    task automatic csr_access(input core_id_t c, input csr_addr_t addr, input logic rw,
                              input word_t wdata, output word_t rdata);
        int gap;
        rdata = '0;
        csr_io_req_valid  <= 1'b1;
        csr_io_req_coreid <= c;
        csr_io_req        <= {addr, rw, wdata};
        do @(posedge clk); while (!csr_io_req_ready);
        csr_io_req_valid <= 1'b0;
        if (!rw) begin
            // Hold off the response for a while now and then
            gap = rand_below(3);
            repeat (gap) @(posedge clk);
            csr_io_rsp_ready <= 1'b1;
            do @(posedge clk); while (!csr_io_rsp_valid);
            rdata = csr_io_rsp_data;
            csr_io_rsp_ready <= 1'b0;
        end
    endtask

    task automatic csr_write(input core_id_t c, input csr_addr_t addr, input word_t wdata);
        word_t unused;
        csr_access(c, addr, 1'b1, wdata, unused);
    endtask

    task automatic csr_read_check(input core_id_t c, input csr_addr_t addr);
        word_t got;
        word_t exp;
        csr_access(c, addr, 1'b0, '0, got);
        exp = expected_csr(c, addr);
        assert (got == exp) else
            fail_run($sformatf("core %0d CSR %h read %h, expected %h", c, addr, got, exp));
    endtask

    task automatic random_op();
        core_id_t  c;
        int        kind;
        word_t     w;
        csr_addr_t a;
        c    = core_id_t'(rand_below(NUM_CORES));
        kind = rand_below(8);
        w    = word_t'($random(seed));
        case (kind)
            0: csr_write(c, CSR_IO_ADDR, {w[31:30], 26'b0, w[3:0]});
            1: csr_write(c, CSR_IO_DATA, w);
            2: csr_write(c, CSR_EBREAK, {w[31:1], rand_below(6) == 0});
            3, 4: begin
                csr_write(c, CSR_IO_CMD, {27'b0, w[4:1], w[0]});
                if (!w[0] && w[8]) begin
                    csr_read_check(c, CSR_IO_RDATA);
                end
            end
            5, 6: begin
                case (rand_below(5))
                    0: a = CSR_IO_ADDR;
                    1: a = CSR_IO_DATA;
                    2: a = CSR_EBREAK;
                    3: a = m_rdata_ok[c] ? CSR_IO_RDATA : CSR_IO_DATA;
                    default: a = 12'h100 + csr_addr_t'(rand_below(16));
                endcase
                csr_read_check(c, a);
            end
            default: begin
                csr_write(c, CSR_IO_DATA, w);
                csr_read_check(c, CSR_IO_DATA);
            end
        endcase
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test finished");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed         = 32'hdee7_3779;
        io_seed      = 32'hdee7_3779 ^ 32'h1357_9bdf;
        cycle        = 0;
        outstanding  = 0;
        launch_total = 0;
        xfer_total   = 0;
        stall_left   = 0;
        rsp_shown    = 1'b0;
        m_ebreak_set = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            m_addr[c]       = '0;
            m_data[c]       = '0;
            m_ebreak_csr[c] = '0;
            m_rdata[c]      = '0;
            m_rdata_ok[c]   = 1'b0;
            m_launches[c]   = '0;
            for (int t = 0; t < 16; t++) begin
                exp_live[c][t] = 1'b0;
            end
        end

        arst_n            = 1'b0;
        csr_io_req_valid  = 1'b0;
        csr_io_req_coreid = '0;
        csr_io_req        = '0;
        csr_io_rsp_ready  = 1'b0;
        io_req_ready      = 1'b0;
        io_rsp_valid      = 1'b0;
        io_rsp            = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Known register contents before random traffic
        for (int c = 0; c < NUM_CORES; c++) begin
            csr_write(core_id_t'(c), CSR_IO_ADDR, word_t'(c));
            csr_write(core_id_t'(c), CSR_IO_DATA, word_t'($random(seed)));
            csr_write(core_id_t'(c), CSR_EBREAK, '0);
        end

        for (int op = 0; op < N_OPS; op++) begin
            random_op();
        end

        while (outstanding != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        assert (xfer_total == launch_total) else
            fail_run($sformatf("%0d transfers for %0d launches", xfer_total, launch_total));
        assert (rsp_due_q.size() == 0) else
            fail_run("read responses left undelivered");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- files.f
hw/cluster_pkg.sv
hw/csr_io_router.sv
hw/core_csr_unit.sv
hw/io_mem_arb.sv
hw/cluster_top.sv
bench/cluster_chk.sv
bench/cluster_tb.sv

//--- hw/cluster_pkg.sv
package cluster_pkg;

    localparam int NUM_CORES  = 4;
    localparam int NC_BITS    = 2;
    localparam int CORE_TAG_W = 4;

    typedef logic [11:0]                    csr_addr_t;
    typedef logic [NC_BITS-1:0]             core_id_t;
    typedef logic [31:0]                    word_t;
    typedef logic [29:0]                    io_addr_t;
    typedef logic [3:0]                     byteen_t;
    typedef logic [CORE_TAG_W-1:0]          core_tag_t;
    // Core tag on top, core index in the low bits
    typedef logic [CORE_TAG_W+NC_BITS-1:0]  io_tag_t;

    localparam csr_addr_t CSR_IO_ADDR  = 12'h7c0;
    localparam csr_addr_t CSR_IO_DATA  = 12'h7c1;
    localparam csr_addr_t CSR_IO_CMD   = 12'h7c2;
    localparam csr_addr_t CSR_IO_RDATA = 12'h7c3;
    localparam csr_addr_t CSR_EBREAK   = 12'h7c4;

    // CMD data layout
    localparam int CMD_RW_BIT = 0;
    localparam int CMD_BE_LSB = 1;

    typedef struct packed {
        csr_addr_t addr;
        logic      rw;
        word_t     data;
    } csr_req_t;

    typedef struct packed {
        logic      rw;
        byteen_t   byteen;
        io_addr_t  addr;
        word_t     data;
        core_tag_t tag;
    } core_io_req_t;

    typedef struct packed {
        logic     rw;
        byteen_t  byteen;
        io_addr_t addr;
        word_t    data;
        io_tag_t  tag;
    } io_req_t;

    typedef struct packed {
        word_t   data;
        io_tag_t tag;
    } io_rsp_t;

    typedef enum logic [1:0] {
        IO_IDLE,
        IO_REQ,
        IO_WAIT
    } io_state_e;

endpackage

//--- hw/cluster_top.sv
module cluster_top
    import cluster_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     csr_io_req_valid,
    input  core_id_t csr_io_req_coreid,
    input  csr_req_t csr_io_req,
    output logic     csr_io_req_ready,

    output logic     csr_io_rsp_valid,
    output word_t    csr_io_rsp_data,
    input  logic     csr_io_rsp_ready,

    output logic     io_req_valid,
    output io_req_t  io_req,
    input  logic     io_req_ready,

    input  logic     io_rsp_valid,
    input  io_rsp_t  io_rsp,
    output logic     io_rsp_ready,

    output logic     busy,
    output logic     ebreak
);

    logic [NUM_CORES-1:0]         core_csr_req_valid;
    csr_req_t                     core_csr_req;
    logic [NUM_CORES-1:0]         core_csr_req_ready;
    logic [NUM_CORES-1:0]         core_csr_rsp_valid;
    word_t [NUM_CORES-1:0]        core_csr_rsp_data;
    logic [NUM_CORES-1:0]         core_csr_rsp_ready;

    logic [NUM_CORES-1:0]         core_io_req_valid;
    core_io_req_t [NUM_CORES-1:0] core_io_req;
    logic [NUM_CORES-1:0]         core_io_req_ready;
    logic [NUM_CORES-1:0]         core_io_rsp_valid;
    word_t [NUM_CORES-1:0]        core_io_rsp_data;
    logic [NUM_CORES-1:0]         core_io_rsp_ready;

    logic [NUM_CORES-1:0]         core_busy;
    logic [NUM_CORES-1:0]         core_ebreak;

    csr_io_router u_csr_router (
        .clk                (clk),
        .arst_n             (arst_n),
        .csr_io_req_valid   (csr_io_req_valid),
        .csr_io_req_coreid  (csr_io_req_coreid),
        .csr_io_req         (csr_io_req),
        .csr_io_req_ready   (csr_io_req_ready),
        .csr_io_rsp_valid   (csr_io_rsp_valid),
        .csr_io_rsp_data    (csr_io_rsp_data),
        .csr_io_rsp_ready   (csr_io_rsp_ready),
        .core_csr_req_valid (core_csr_req_valid),
        .core_csr_req       (core_csr_req),
        .core_csr_req_ready (core_csr_req_ready),
        .core_csr_rsp_valid (core_csr_rsp_valid),
        .core_csr_rsp_data  (core_csr_rsp_data),
        .core_csr_rsp_ready (core_csr_rsp_ready)
    );

    for (genvar i = 0; i < NUM_CORES; i++) begin : gen_core
        core_csr_unit u_core (
            .clk           (clk),
            .arst_n        (arst_n),
            .csr_req_valid (core_csr_req_valid[i]),
            .csr_req       (core_csr_req),
            .csr_req_ready (core_csr_req_ready[i]),
            .csr_rsp_valid (core_csr_rsp_valid[i]),
            .csr_rsp_data  (core_csr_rsp_data[i]),
            .csr_rsp_ready (core_csr_rsp_ready[i]),
            .io_req_valid  (core_io_req_valid[i]),
            .core_io_req   (core_io_req[i]),
            .io_req_ready  (core_io_req_ready[i]),
            .io_rsp_valid  (core_io_rsp_valid[i]),
            .io_rsp_data   (core_io_rsp_data[i]),
            .io_rsp_ready  (core_io_rsp_ready[i]),
            .busy          (core_busy[i]),
            .ebreak        (core_ebreak[i])
        );
    end

    io_mem_arb u_io_arb (
        .clk               (clk),
        .arst_n            (arst_n),
        .core_io_req_valid (core_io_req_valid),
        .core_io_req       (core_io_req),
        .core_io_req_ready (core_io_req_ready),
        .core_io_rsp_valid (core_io_rsp_valid),
        .core_io_rsp_data  (core_io_rsp_data),
        .core_io_rsp_ready (core_io_rsp_ready),
        .core_busy         (core_busy),
        .core_ebreak       (core_ebreak),
        .io_req_valid      (io_req_valid),
        .io_req            (io_req),
        .io_req_ready      (io_req_ready),
        .io_rsp_valid      (io_rsp_valid),
        .io_rsp            (io_rsp),
        .io_rsp_ready      (io_rsp_ready),
        .busy              (busy),
        .ebreak            (ebreak)
    );

endmodule

//--- hw/core_csr_unit.sv
module core_csr_unit
    import cluster_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    input  logic         csr_req_valid,
    input  csr_req_t     csr_req,
    output logic         csr_req_ready,
    output logic         csr_rsp_valid,
    output word_t        csr_rsp_data,
    input  logic         csr_rsp_ready,

    output logic         io_req_valid,
    output core_io_req_t core_io_req,
    input  logic         io_req_ready,
    input  logic         io_rsp_valid,
    input  word_t        io_rsp_data,
    output logic         io_rsp_ready,

    output logic         busy,
    output logic         ebreak
);

    io_state_e state_q;
    logic      rsp_valid_q;
    core_tag_t tag_q;
    logic      ebreak_q;

    word_t     addr_q;
    word_t     data_q;
    word_t     rdata_q;
    word_t     ebreak_csr_q;
    logic      rw_q;
    byteen_t   byteen_q;
    word_t     rsp_data_q;

    logic      csr_fire;
    logic      wr_fire;
    logic      rd_fire;
    logic      cmd_fire;
    word_t     rd_data;

    // CSR access only while no I/O is outstanding
    assign csr_req_ready = (state_q == IO_IDLE) && !rsp_valid_q;
    assign csr_fire      = csr_req_valid && csr_req_ready;
    assign wr_fire       = csr_fire && csr_req.rw;
    assign rd_fire       = csr_fire && !csr_req.rw;
    assign cmd_fire      = wr_fire && (csr_req.addr == CSR_IO_CMD);

    always_comb begin
        case (csr_req.addr)
            CSR_IO_ADDR:  rd_data = addr_q;
            CSR_IO_DATA:  rd_data = data_q;
            CSR_IO_CMD:   rd_data = {27'b0, byteen_q, rw_q};
            CSR_IO_RDATA: rd_data = rdata_q;
            CSR_EBREAK:   rd_data = ebreak_csr_q;
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= IO_IDLE;
            rsp_valid_q <= 1'b0;
            tag_q       <= '0;
            ebreak_q    <= 1'b0;
        end else begin
            if (rd_fire) begin
                rsp_valid_q <= 1'b1;
            end else if (csr_rsp_ready) begin
                rsp_valid_q <= 1'b0;
            end

            // Sticky until reset
            if (wr_fire && (csr_req.addr == CSR_EBREAK) && csr_req.data[0]) begin
                ebreak_q <= 1'b1;
            end

            case (state_q)
                IO_IDLE: begin
                    if (cmd_fire) begin
                        state_q <= IO_REQ;
                        tag_q   <= tag_q + 1'b1;
                    end
                end
                IO_REQ: begin
                    // Writes get no response
                    if (io_req_ready) begin
                        state_q <= rw_q ? IO_IDLE : IO_WAIT;
                    end
                end
                IO_WAIT: begin
                    if (io_rsp_valid) begin
                        state_q <= IO_IDLE;
                    end
                end
                default: state_q <= IO_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            case (csr_req.addr)
                CSR_IO_ADDR: addr_q <= csr_req.data;
                CSR_IO_DATA: data_q <= csr_req.data;
                CSR_IO_CMD: begin
                    rw_q     <= csr_req.data[CMD_RW_BIT];
                    byteen_q <= csr_req.data[CMD_BE_LSB +: 4];
                end
                CSR_EBREAK:  ebreak_csr_q <= csr_req.data;
                default: ;
            endcase
        end
        if (rd_fire) begin
            rsp_data_q <= rd_data;
        end
        if (io_rsp_valid && io_rsp_ready) begin
            rdata_q <= io_rsp_data;
        end
    end

    assign csr_rsp_valid = rsp_valid_q;
    assign csr_rsp_data  = rsp_data_q;

    assign io_req_valid       = (state_q == IO_REQ);
    assign core_io_req.rw     = rw_q;
    assign core_io_req.byteen = byteen_q;
    assign core_io_req.addr   = addr_q[29:0];
    assign core_io_req.data   = data_q;
    assign core_io_req.tag    = tag_q;

    assign io_rsp_ready = (state_q == IO_WAIT);

    assign busy   = (state_q != IO_IDLE);
    assign ebreak = ebreak_q;

endmodule

//--- hw/csr_io_router.sv
module csr_io_router
    import cluster_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     csr_io_req_valid,
    input  core_id_t                 csr_io_req_coreid,
    input  csr_req_t                 csr_io_req,
    output logic                     csr_io_req_ready,

    output logic                     csr_io_rsp_valid,
    output word_t                    csr_io_rsp_data,
    input  logic                     csr_io_rsp_ready,

    output logic [NUM_CORES-1:0]     core_csr_req_valid,
    output csr_req_t                 core_csr_req,
    input  logic [NUM_CORES-1:0]     core_csr_req_ready,

    input  logic [NUM_CORES-1:0]     core_csr_rsp_valid,
    input  word_t [NUM_CORES-1:0]    core_csr_rsp_data,
    output logic [NUM_CORES-1:0]     core_csr_rsp_ready
);

    logic     pending_q;
    core_id_t pending_core_q;
    logic     req_fire;
    logic     rsp_fire;

    // One read in flight at a time
    assign csr_io_req_ready = core_csr_req_ready[csr_io_req_coreid] && !pending_q;
    assign req_fire         = csr_io_req_valid && csr_io_req_ready;

    assign core_csr_req = csr_io_req;

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_csr_req_valid[i] = csr_io_req_valid && !pending_q
                                    && (csr_io_req_coreid == core_id_t'(i));
            core_csr_rsp_ready[i] = pending_q && csr_io_rsp_ready
                                    && (pending_core_q == core_id_t'(i));
        end
    end

    // Only the core that owes the read may answer
    assign csr_io_rsp_valid = pending_q && core_csr_rsp_valid[pending_core_q];
    assign csr_io_rsp_data  = core_csr_rsp_data[pending_core_q];
    assign rsp_fire         = csr_io_rsp_valid && csr_io_rsp_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q      <= 1'b0;
            pending_core_q <= '0;
        end else begin
            if (req_fire && !csr_io_req.rw) begin
                pending_q      <= 1'b1;
                pending_core_q <= csr_io_req_coreid;
            end else if (rsp_fire) begin
                pending_q <= 1'b0;
            end
        end
    end

endmodule

//--- hw/io_mem_arb.sv
module io_mem_arb
    import cluster_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic [NUM_CORES-1:0]          core_io_req_valid,
    input  core_io_req_t [NUM_CORES-1:0]  core_io_req,
    output logic [NUM_CORES-1:0]          core_io_req_ready,

    output logic [NUM_CORES-1:0]          core_io_rsp_valid,
    output word_t [NUM_CORES-1:0]         core_io_rsp_data,
    input  logic [NUM_CORES-1:0]          core_io_rsp_ready,

    input  logic [NUM_CORES-1:0]          core_busy,
    input  logic [NUM_CORES-1:0]          core_ebreak,

    output logic                          io_req_valid,
    output io_req_t                       io_req,
    input  logic                          io_req_ready,

    input  logic                          io_rsp_valid,
    input  io_rsp_t                       io_rsp,
    output logic                          io_rsp_ready,

    output logic                          busy,
    output logic                          ebreak
);

    core_id_t ptr_q;
    logic     stage_valid_q;
    io_req_t  stage_q;

    logic     stage_load;
    logic     grant_valid;
    core_id_t grant_idx;
    core_id_t rsp_idx;

    // Stage accepts when empty or being drained this cycle
    assign stage_load = !stage_valid_q || io_req_ready;

    // First requester at or after the pointer wins
    always_comb begin
        core_id_t idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < NUM_CORES; k++) begin
            idx = core_id_t'(ptr_q + core_id_t'(k));
            if (!grant_valid && core_io_req_valid[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_io_req_ready[i] = stage_load && grant_valid
                                   && (grant_idx == core_id_t'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid_q <= 1'b0;
            ptr_q         <= '0;
        end else begin
            if (stage_load) begin
                stage_valid_q <= grant_valid;
            end
            if (stage_load && grant_valid) begin
                ptr_q <= grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load && grant_valid) begin
            stage_q.rw     <= core_io_req[grant_idx].rw;
            stage_q.byteen <= core_io_req[grant_idx].byteen;
            stage_q.addr   <= core_io_req[grant_idx].addr;
            stage_q.data   <= core_io_req[grant_idx].data;
            stage_q.tag    <= {core_io_req[grant_idx].tag, grant_idx};
        end
    end

    assign io_req_valid = stage_valid_q;
    assign io_req       = stage_q;

    // Response goes back to the core named in the low tag bits
    assign rsp_idx = io_rsp.tag[NC_BITS-1:0];

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_io_rsp_valid[i] = io_rsp_valid && (rsp_idx == core_id_t'(i));
            core_io_rsp_data[i]  = io_rsp.data;
        end
    end

    assign io_rsp_ready = core_io_rsp_ready[rsp_idx];

    assign busy   = (|core_busy) || stage_valid_q;
    assign ebreak = &core_ebreak;

endmodule
